// File: rtl/csr_pkg.sv
// shared widths, machine CSR addresses and encodings for the CSR subsystem
// imported by the exec unit, CSR file, counters and interfaces
package csr_pkg;

    localparam int XLEN        = 32;
    localparam int CSR_ADDR_W  = 12;
    localparam int REG_ADDR_W  = 5;
    localparam int COMMIT_ID_W = 4;

    // operation as decoded by the dispatcher
    typedef enum logic [1:0] {
        CSR_OP_RW,  // write operand 1
        CSR_OP_RS,  // set bits of operand 1
        CSR_OP_RC   // clear bits of operand 1
    } csr_op_e;

    // machine-mode CSR addresses
    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS   = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIE       = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC     = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH  = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC      = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE    = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLE    = 12'hB00;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLEH   = 12'hB80;
    localparam logic [CSR_ADDR_W-1:0] CSR_MINSTRET  = 12'hB02;
    localparam logic [CSR_ADDR_W-1:0] CSR_MINSTRETH = 12'hB82;

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MIE_MEIE_BIT     = 11;

    // interrupt bit set with code 11
    localparam logic [XLEN-1:0] MCAUSE_MEI = 32'h8000_000B;

endpackage

// File: rtl/csr_if.sv
// bundles between exec unit, CSR file, counters and trap FSM
// csr_access_if carries the head op's CSR access, trap_ctrl_if the interrupt entry
`timescale 1ns/1ps

interface csr_access_if;
    import csr_pkg::*;

    logic [CSR_ADDR_W-1:0] addr;
    logic [XLEN-1:0]       wdata;
    logic [XLEN-1:0]       rdata;   // old value, combinational from addr
    logic                  we;
    logic                  retire;  // one completion

    modport exec    (output addr, wdata, we, retire, input rdata);
    modport regfile (input addr, wdata, we, output rdata);
    modport counter (input retire, addr, wdata, we);
endinterface

interface trap_ctrl_if;
    import csr_pkg::*;

    logic            irq_enable;  // mstatus.MIE and mie.MEIE
    logic [XLEN-1:0] mtvec;
    logic            flush;
    logic            save;
    logic            busy;        // FLUSH, SAVE or ENTER
    logic [XLEN-1:0] epc;

    modport exec    (input flush, busy);
    modport regfile (input save, epc, output irq_enable, mtvec);
    modport fsm     (input irq_enable, mtvec, output flush, save, busy, epc);
endinterface

// File: rtl/csr_exec_unit.sv
// dual-slot in-order CSR queue with empty-queue bypass
// executes the head op against the CSR file and hands the old value to writeback
`timescale 1ns/1ps

module csr_exec_unit #(
    parameter int unsigned QUEUE_DEPTH = 4
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            req_0_i,
    input  csr_pkg::csr_op_e                op_0_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]  addr_0_i,
    input  logic [csr_pkg::XLEN-1:0]        op1_0_i,
    input  logic [csr_pkg::COMMIT_ID_W-1:0] commit_id_0_i,
    input  logic                            csr_we_0_i,
    input  logic                            rd_we_0_i,
    input  logic [csr_pkg::REG_ADDR_W-1:0]  rd_0_i,
    input  logic                            req_1_i,
    input  csr_pkg::csr_op_e                op_1_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]  addr_1_i,
    input  logic [csr_pkg::XLEN-1:0]        op1_1_i,
    input  logic [csr_pkg::COMMIT_ID_W-1:0] commit_id_1_i,
    input  logic                            csr_we_1_i,
    input  logic                            rd_we_1_i,
    input  logic [csr_pkg::REG_ADDR_W-1:0]  rd_1_i,
    output logic                            stall_o,
    input  logic                            wb_ready_i,
    output logic                            wb_valid_o,
    output logic [csr_pkg::XLEN-1:0]        wb_rdata_o,
    output logic [csr_pkg::REG_ADDR_W-1:0]  wb_rd_o,
    output logic                            wb_rd_we_o,
    output logic [csr_pkg::COMMIT_ID_W-1:0] wb_commit_id_o,
    csr_access_if.exec                      acc,
    trap_ctrl_if.exec                       trap
);
    import csr_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    typedef struct packed {
        csr_op_e                op;
        logic [CSR_ADDR_W-1:0]  addr;
        logic [XLEN-1:0]        op1;
        logic [COMMIT_ID_W-1:0] commit_id;
        logic                   csr_we;
        logic                   rd_we;
        logic [REG_ADDR_W-1:0]  rd;
    } entry_t;

    entry_t           mem [QUEUE_DEPTH];
    logic [PTR_W:0]   wr_ptr;   // extra bit tells full from empty
    logic [PTR_W:0]   rd_ptr;
    logic [PTR_W:0]   q_count;
    logic [PTR_W:0]   free_cnt;
    logic [PTR_W-1:0] wr_idx_1;
    logic [1:0]       n_req;
    logic [1:0]       push_cnt;
    logic             q_empty;
    logic             accept;
    logic             bypass;
    logic             bypass_done;
    logic             complete;
    entry_t           slot_0;
    entry_t           slot_1;
    entry_t           first_push;
    entry_t           head;
    logic [XLEN-1:0]  new_val;

    assign slot_0 = '{op: op_0_i, addr: addr_0_i, op1: op1_0_i, commit_id: commit_id_0_i,
                      csr_we: csr_we_0_i, rd_we: rd_we_0_i, rd: rd_0_i};
    assign slot_1 = '{op: op_1_i, addr: addr_1_i, op1: op1_1_i, commit_id: commit_id_1_i,
                      csr_we: csr_we_1_i, rd_we: rd_we_1_i, rd: rd_1_i};

    assign q_count  = wr_ptr - rd_ptr;
    assign free_cnt = (PTR_W+1)'(QUEUE_DEPTH) - q_count;
    assign q_empty  = (q_count == '0);
    assign n_req    = {1'b0, req_0_i} + {1'b0, req_1_i};

    // free space is judged before this cycle's pop
    assign stall_o = (free_cnt < (PTR_W+1)'(n_req)) | trap.busy;
    assign accept  = ~stall_o & (req_0_i | req_1_i);
    assign bypass  = q_empty & accept;

    // oldest op is the queue head, else the oldest offered slot
    assign head = q_empty ? (req_0_i ? slot_0 : slot_1) : mem[rd_ptr[PTR_W-1:0]];

    assign wb_valid_o  = (~q_empty | bypass) & ~trap.flush;
    assign complete    = wb_valid_o & wb_ready_i;
    assign bypass_done = bypass & complete;

    // a bypassed op that completes is not queued
    assign push_cnt   = accept ? (n_req - {1'b0, bypass_done}) : 2'd0;
    assign first_push = bypass_done ? slot_1 : (req_0_i ? slot_0 : slot_1);
    assign wr_idx_1   = wr_ptr[PTR_W-1:0] + 1'b1;  // wraps since depth is a power of two

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (trap.flush) begin
            wr_ptr <= '0;  // drop all pending work
            rd_ptr <= '0;
        end else begin
            wr_ptr <= wr_ptr + (PTR_W+1)'(push_cnt);
            if (complete && !q_empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_cnt != 2'd0) begin
            mem[wr_ptr[PTR_W-1:0]] <= first_push;
        end
        if (push_cnt == 2'd2) begin
            mem[wr_idx_1] <= slot_1;  // slot 1 behind slot 0
        end
    end

    always_comb begin
        case (head.op)
            CSR_OP_RS: new_val = acc.rdata | head.op1;
            CSR_OP_RC: new_val = acc.rdata & ~head.op1;
            default:   new_val = head.op1;
        endcase
    end

    assign acc.addr   = head.addr;
    assign acc.wdata  = new_val;
    assign acc.we     = complete & head.csr_we;
    assign acc.retire = complete;

    assign wb_rdata_o     = acc.rdata;  // old CSR value to rd
    assign wb_rd_o        = head.rd;
    assign wb_rd_we_o     = head.rd_we;
    assign wb_commit_id_o = head.commit_id;

endmodule

// File: rtl/csr_regfile.sv
// machine-mode CSR storage with write masks and read decode
// also reads out the counters and performs the interrupt entry update
`timescale 1ns/1ps

module csr_regfile #(
    parameter logic [csr_pkg::XLEN-1:0] MTVEC_RESET = 32'h0000_0100
) (
    input  logic                       clk,
    input  logic                       rst_n,
    csr_access_if.regfile              acc,
    trap_ctrl_if.regfile               trap,
    input  logic [2*csr_pkg::XLEN-1:0] mcycle_i,
    input  logic [2*csr_pkg::XLEN-1:0] minstret_i
);
    import csr_pkg::*;

    // writable bits per register
    localparam logic [XLEN-1:0] MSTATUS_WMASK = (XLEN'(1) << MSTATUS_MIE_BIT) |
                                                (XLEN'(1) << MSTATUS_MPIE_BIT);
    localparam logic [XLEN-1:0] MIE_WMASK     = XLEN'(1) << MIE_MEIE_BIT;
    localparam logic [XLEN-1:0] ALIGN_MASK    = 32'hFFFF_FFFC;

    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] mie;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mscratch;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;

    always_comb begin
        case (acc.addr)
            CSR_MSTATUS:   acc.rdata = mstatus;
            CSR_MIE:       acc.rdata = mie;
            CSR_MTVEC:     acc.rdata = mtvec;
            CSR_MSCRATCH:  acc.rdata = mscratch;
            CSR_MEPC:      acc.rdata = mepc;
            CSR_MCAUSE:    acc.rdata = mcause;
            CSR_MCYCLE:    acc.rdata = mcycle_i[XLEN-1:0];
            CSR_MCYCLEH:   acc.rdata = mcycle_i[2*XLEN-1:XLEN];
            CSR_MINSTRET:  acc.rdata = minstret_i[XLEN-1:0];
            CSR_MINSTRETH: acc.rdata = minstret_i[2*XLEN-1:XLEN];
            default:       acc.rdata = '0;  // unmapped
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus  <= '0;
            mie      <= '0;
            mtvec    <= MTVEC_RESET & ALIGN_MASK;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
        end else if (trap.save) begin
            // interrupt entry stacks MIE and then disables it
            mstatus[MSTATUS_MPIE_BIT] <= mstatus[MSTATUS_MIE_BIT];
            mstatus[MSTATUS_MIE_BIT]  <= 1'b0;
            mepc                      <= trap.epc & ALIGN_MASK;
            mcause                    <= MCAUSE_MEI;
        end else if (acc.we) begin
            case (acc.addr)
                CSR_MSTATUS:  mstatus  <= acc.wdata & MSTATUS_WMASK;
                CSR_MIE:      mie      <= acc.wdata & MIE_WMASK;
                CSR_MTVEC:    mtvec    <= acc.wdata & ALIGN_MASK;
                CSR_MSCRATCH: mscratch <= acc.wdata;
                CSR_MEPC:     mepc     <= acc.wdata & ALIGN_MASK;
                CSR_MCAUSE:   mcause   <= acc.wdata;
                default:      ;  // counters live elsewhere
            endcase
        end
    end

    assign trap.irq_enable = mstatus[MSTATUS_MIE_BIT] & mie[MIE_MEIE_BIT];
    assign trap.mtvec      = mtvec;

endmodule

// File: rtl/csr_counters.sv
// 64-bit mcycle and minstret counters
// either half is writable by a CSR op; the write wins over the increment
`timescale 1ns/1ps

module csr_counters (
    input  logic                       clk,
    input  logic                       rst_n,
    csr_access_if.counter              acc,
    output logic [2*csr_pkg::XLEN-1:0] mcycle_o,
    output logic [2*csr_pkg::XLEN-1:0] minstret_o
);
    import csr_pkg::*;

    logic [2*XLEN-1:0] mcycle;
    logic [2*XLEN-1:0] minstret;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mcycle <= '0;
        end else if (acc.we && acc.addr == CSR_MCYCLE) begin
            mcycle <= {mcycle[2*XLEN-1:XLEN], acc.wdata};
        end else if (acc.we && acc.addr == CSR_MCYCLEH) begin
            mcycle <= {acc.wdata, mcycle[XLEN-1:0]};
        end else begin
            mcycle <= mcycle + 1'b1;  // free running
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            minstret <= '0;
        end else if (acc.we && acc.addr == CSR_MINSTRET) begin
            minstret <= {minstret[2*XLEN-1:XLEN], acc.wdata};
        end else if (acc.we && acc.addr == CSR_MINSTRETH) begin
            minstret <= {acc.wdata, minstret[XLEN-1:0]};
        end else if (acc.retire) begin
            minstret <= minstret + 1'b1;
        end
    end

    assign mcycle_o   = mcycle;
    assign minstret_o = minstret;

endmodule

// File: rtl/csr_trap_fsm.sv
// machine external interrupt entry sequencer
// IDLE -> FLUSH -> SAVE -> ENTER -> IDLE, one cycle per step
`timescale 1ns/1ps

module csr_trap_fsm (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     irq_i,
    input  logic [csr_pkg::XLEN-1:0] pc_i,
    trap_ctrl_if.fsm                 trap,
    output logic                     trap_o,
    output logic [csr_pkg::XLEN-1:0] trap_pc_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FLUSH,  // drop queued ops
        ST_SAVE,   // mepc, mcause, mstatus update
        ST_ENTER   // redirect to mtvec
    } state_e;

    state_e state;
    state_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (irq_i && trap.irq_enable) begin
                    state_nxt = ST_FLUSH;
                end
            end
            ST_FLUSH: state_nxt = ST_SAVE;
            ST_SAVE:  state_nxt = ST_ENTER;
            default:  state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // pc at the moment the interrupt is taken
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && state_nxt == ST_FLUSH) begin
            trap.epc <= pc_i;
        end
    end

    assign trap.flush = (state == ST_FLUSH);
    assign trap.save  = (state == ST_SAVE);
    assign trap.busy  = (state != ST_IDLE);

    assign trap_o    = (state == ST_ENTER);
    assign trap_pc_o = trap.mtvec;

endmodule

// File: rtl/csr_subsys_top.sv
// CSR execution subsystem top: dual issue slots in, one writeback port out
// connects exec unit, CSR file, counters and trap FSM through the two interfaces
`timescale 1ns/1ps

module csr_subsys_top #(
    parameter int unsigned              QUEUE_DEPTH = 4,
    parameter logic [csr_pkg::XLEN-1:0] MTVEC_RESET = 32'h0000_0100
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [csr_pkg::XLEN-1:0]        pc_i,
    input  logic                            irq_i,
    input  logic                            req_0_i,
    input  csr_pkg::csr_op_e                op_0_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]  addr_0_i,
    input  logic [csr_pkg::XLEN-1:0]        op1_0_i,
    input  logic [csr_pkg::COMMIT_ID_W-1:0] commit_id_0_i,
    input  logic                            csr_we_0_i,
    input  logic                            rd_we_0_i,
    input  logic [csr_pkg::REG_ADDR_W-1:0]  rd_0_i,
    input  logic                            req_1_i,
    input  csr_pkg::csr_op_e                op_1_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]  addr_1_i,
    input  logic [csr_pkg::XLEN-1:0]        op1_1_i,
    input  logic [csr_pkg::COMMIT_ID_W-1:0] commit_id_1_i,
    input  logic                            csr_we_1_i,
    input  logic                            rd_we_1_i,
    input  logic [csr_pkg::REG_ADDR_W-1:0]  rd_1_i,
    output logic                            stall_o,
    input  logic                            wb_ready_i,
    output logic                            wb_valid_o,
    output logic [csr_pkg::XLEN-1:0]        wb_rdata_o,
    output logic [csr_pkg::REG_ADDR_W-1:0]  wb_rd_o,
    output logic                            wb_rd_we_o,
    output logic [csr_pkg::COMMIT_ID_W-1:0] wb_commit_id_o,
    output logic                            trap_o,
    output logic [csr_pkg::XLEN-1:0]        trap_pc_o
);

    logic [2*csr_pkg::XLEN-1:0] mcycle;
    logic [2*csr_pkg::XLEN-1:0] minstret;

    csr_access_if acc_if ();
    trap_ctrl_if  trap_if ();

    csr_exec_unit #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_exec (
        .clk            (clk),            .rst_n         (rst_n),
        .req_0_i        (req_0_i),        .op_0_i        (op_0_i),
        .addr_0_i       (addr_0_i),       .op1_0_i       (op1_0_i),
        .commit_id_0_i  (commit_id_0_i),  .csr_we_0_i    (csr_we_0_i),
        .rd_we_0_i      (rd_we_0_i),      .rd_0_i        (rd_0_i),
        .req_1_i        (req_1_i),        .op_1_i        (op_1_i),
        .addr_1_i       (addr_1_i),       .op1_1_i       (op1_1_i),
        .commit_id_1_i  (commit_id_1_i),  .csr_we_1_i    (csr_we_1_i),
        .rd_we_1_i      (rd_we_1_i),      .rd_1_i        (rd_1_i),
        .stall_o        (stall_o),        .wb_ready_i    (wb_ready_i),
        .wb_valid_o     (wb_valid_o),     .wb_rdata_o    (wb_rdata_o),
        .wb_rd_o        (wb_rd_o),        .wb_rd_we_o    (wb_rd_we_o),
        .wb_commit_id_o (wb_commit_id_o),
        .acc            (acc_if.exec),
        .trap           (trap_if.exec)
    );

    csr_regfile #(
        .MTVEC_RESET (MTVEC_RESET)
    ) u_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .acc        (acc_if.regfile),
        .trap       (trap_if.regfile),
        .mcycle_i   (mcycle),
        .minstret_i (minstret)
    );

    csr_counters u_counters (
        .clk        (clk),
        .rst_n      (rst_n),
        .acc        (acc_if.counter),
        .mcycle_o   (mcycle),
        .minstret_o (minstret)
    );

    csr_trap_fsm u_trap_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .irq_i     (irq_i),
        .pc_i      (pc_i),
        .trap      (trap_if.fsm),
        .trap_o    (trap_o),
        .trap_pc_o (trap_pc_o)
    );

endmodule

// File: dv/csr_subsys_tb.sv
// testbench for the CSR execution subsystem
// seeded random dual-issue traffic checked against a shadow CSR model,
// then directed back-pressure and interrupt entry sequences
`timescale 1ns/1ps

module csr_subsys_tb;
    import csr_pkg::*;

    localparam int              QUEUE_DEPTH = 4;
    localparam logic [XLEN-1:0] MTVEC_RESET = 32'h0000_0100;
    localparam logic [XLEN-1:0] IRQ_PC      = 32'h0000_2468;
    localparam int              RAND_CYCLES = 1500;
    localparam int              PLAN_CYCLES = RAND_CYCLES + 600;

    typedef struct packed {
        csr_op_e                op;
        logic [CSR_ADDR_W-1:0]  addr;
        logic [XLEN-1:0]        op1;
        logic [COMMIT_ID_W-1:0] cid;
        logic                   csr_we;
        logic                   rd_we;
        logic [REG_ADDR_W-1:0]  rd;
    } op_t;

    // mapped CSRs, counter halves, one unmapped address
    localparam logic [CSR_ADDR_W-1:0] ADDR_LIST [11] = '{CSR_MSTATUS, CSR_MIE, CSR_MTVEC,
        CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE, CSR_MCYCLE, CSR_MCYCLEH, CSR_MINSTRET,
        CSR_MINSTRETH, 12'h7C0};
    // writable bits of mstatus, mie, mtvec, mscratch, mepc, mcause
    localparam logic [XLEN-1:0] WMASK [6] = '{32'h0000_0088, 32'h0000_0800, 32'hFFFF_FFFC,
        32'hFFFF_FFFF, 32'hFFFF_FFFC, 32'hFFFF_FFFF};

    logic                   clk;
    logic                   rst_n;
    logic                   irq_i;
    logic [XLEN-1:0]        pc_i;
    logic                   req_0;
    logic                   req_1;
    op_t                    s0;
    op_t                    s1;
    logic                   wb_ready_i;
    logic                   stall_o;
    logic                   wb_valid_o;
    logic [XLEN-1:0]        wb_rdata_o;
    logic [REG_ADDR_W-1:0]  wb_rd_o;
    logic                   wb_rd_we_o;
    logic [COMMIT_ID_W-1:0] wb_commit_id_o;
    logic                   trap_o;
    logic [XLEN-1:0]        trap_pc_o;

    op_t                    model_q [$];  // accepted, not yet completed
    op_t                    dir_q [$];    // directed ops waiting for issue
    logic [XLEN-1:0]        csr_m [6];
    logic [2*XLEN-1:0]      mcyc_m;
    logic [2*XLEN-1:0]      minst_m;
    logic [XLEN-1:0]        epc_m;
    logic [XLEN-1:0]        seen_rd [logic [CSR_ADDR_W-1:0]];  // last rdata per address
    logic [XLEN-1:0]        rd_tmp;
    logic [COMMIT_ID_W-1:0] next_cid;
    int                     seed;
    int                     phase;       // 0 idle, 1 flush, 2 save, 3 enter
    int                     ready_mode;  // 0 random, 1 low, 2 high
    int                     traps;
    int                     traps_before;
    bit                     rand_en;
    bit                     stalled;
    bit                     irq_req;

    csr_subsys_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .MTVEC_RESET (MTVEC_RESET)
    ) DUT (
        .clk            (clk),            .rst_n         (rst_n),
        .pc_i           (pc_i),           .irq_i         (irq_i),
        .req_0_i        (req_0),          .op_0_i        (s0.op),
        .addr_0_i       (s0.addr),        .op1_0_i       (s0.op1),
        .commit_id_0_i  (s0.cid),         .csr_we_0_i    (s0.csr_we),
        .rd_we_0_i      (s0.rd_we),       .rd_0_i        (s0.rd),
        .req_1_i        (req_1),          .op_1_i        (s1.op),
        .addr_1_i       (s1.addr),        .op1_1_i       (s1.op1),
        .commit_id_1_i  (s1.cid),         .csr_we_1_i    (s1.csr_we),
        .rd_we_1_i      (s1.rd_we),       .rd_1_i        (s1.rd),
        .stall_o        (stall_o),        .wb_ready_i    (wb_ready_i),
        .wb_valid_o     (wb_valid_o),     .wb_rdata_o    (wb_rdata_o),
        .wb_rd_o        (wb_rd_o),        .wb_rd_we_o    (wb_rd_we_o),
        .wb_commit_id_o (wb_commit_id_o), .trap_o        (trap_o),
        .trap_pc_o      (trap_pc_o)
    );

    always #10 clk = ~clk;

    task automatic abort_run(input string why);
        $display("tests failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_data(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
            abort_run("data mismatch");
        end
    endtask

    task automatic check_tag(input string name, input logic [COMMIT_ID_W-1:0] exp,
                             input logic [COMMIT_ID_W-1:0] act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
            abort_run("commit id mismatch");
        end
    endtask

    task automatic check_rd(input string name, input logic [REG_ADDR_W-1:0] exp,
                            input logic [REG_ADDR_W-1:0] act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %0d actual %0d", $time, name, exp, act);
            abort_run("register index mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %b actual %b", $time, name, exp, act);
            abort_run("flag mismatch");
        end
    endtask

    function automatic int csr_index(input logic [CSR_ADDR_W-1:0] a);
        case (a)
            CSR_MSTATUS:  return 0;
            CSR_MIE:      return 1;
            CSR_MTVEC:    return 2;
            CSR_MSCRATCH: return 3;
            CSR_MEPC:     return 4;
            CSR_MCAUSE:   return 5;
            default:      return -1;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] read_model(input logic [CSR_ADDR_W-1:0] a);
        int ix;
        ix = csr_index(a);
        if (ix >= 0) return csr_m[ix[2:0]];
        case (a)
            CSR_MCYCLE:    return mcyc_m[XLEN-1:0];
            CSR_MCYCLEH:   return mcyc_m[2*XLEN-1:XLEN];
            CSR_MINSTRET:  return minst_m[XLEN-1:0];
            CSR_MINSTRETH: return minst_m[2*XLEN-1:XLEN];
            default:       return '0;  // unmapped
        endcase
    endfunction

    function automatic logic [XLEN-1:0] apply_op(input csr_op_e op,
                                                 input logic [XLEN-1:0] old_v,
                                                 input logic [XLEN-1:0] op1);
        case (op)
            CSR_OP_RS: return old_v | op1;
            CSR_OP_RC: return old_v & ~op1;
            default:   return op1;
        endcase
    endfunction

    task automatic gen_op(output op_t o);
        int r_op;
        int r_addr;
        int r_bits;
        r_op   = {$random(seed)} % 3;
        r_addr = {$random(seed)} % 11;
        r_bits = $random(seed);
        o = '{csr_op_e'(r_op[1:0]), ADDR_LIST[r_addr[3:0]], $random(seed), next_cid,
              r_bits[0], r_bits[1], r_bits[6:2]};
        next_cid = next_cid + 1'b1;
    endtask

    task automatic queue_op(input csr_op_e op, input logic [CSR_ADDR_W-1:0] a,
                            input logic [XLEN-1:0] v, input logic we);
        op_t o;
        o = '{op, a, v, next_cid, we, 1'b1, 5'd1};
        dir_q.push_back(o);
        next_cid = next_cid + 1'b1;
    endtask

    // new slots only when the last offer was taken
    task automatic drive();
        int   r;
        op_t  t0;
        op_t  t1;
        r = {$random(seed)} % 10;
        wb_ready_i <= (ready_mode == 0) ? (r >= 3) : (ready_mode == 2);
        irq_i      <= irq_req;
        if (!stalled) begin
            req_0 <= 1'b0;
            req_1 <= 1'b0;
            r = {$random(seed)} % 3;
            if (dir_q.size() != 0) begin
                s0    <= dir_q.pop_front();
                req_0 <= 1'b1;
            end else if (rand_en && r == 2) begin
                gen_op(t0);
                gen_op(t1);  // slot 1 is younger
                s0    <= t0;
                s1    <= t1;
                req_0 <= 1'b1;
                req_1 <= 1'b1;
            end else if (rand_en && r == 1) begin
                gen_op(t0);
                r = $random(seed);
                s0    <= t0;
                s1    <= t0;
                req_0 <= r[0];
                req_1 <= ~r[0];
            end
        end
    endtask

    // sampled at the falling edge to predict the next rising edge
    task automatic monitor();
        int              nreq;
        int              nxt;
        bit              exp_stall;
        bit              exp_valid;
        bit              done;
        bit              cyc_wr;
        bit              ins_wr;
        op_t             e;
        logic [XLEN-1:0] new_v;
        nreq      = int'(req_0) + int'(req_1);
        exp_stall = (phase != 0) || (QUEUE_DEPTH - model_q.size() < nreq);
        exp_valid = (phase != 1) && (model_q.size() != 0 || (nreq != 0 && !exp_stall));
        check_flag("stall_o", exp_stall, stall_o);
        check_flag("wb_valid_o", exp_valid, wb_valid_o);
        check_flag("trap_o", phase == 3, trap_o);
        if (phase == 3) begin
            check_data("trap_pc_o", csr_m[2], trap_pc_o);
        end
        if (trap_o) traps++;
        // irq_enable comes from the CSR values before this edge
        if (phase == 0) begin
            nxt = (irq_i && csr_m[0][MSTATUS_MIE_BIT] && csr_m[1][MIE_MEIE_BIT]) ? 1 : 0;
        end else begin
            nxt = (phase + 1) % 4;
        end
        if (phase == 0 && nxt == 1) epc_m = pc_i;
        stalled = exp_stall;
        if (!exp_stall && req_0) begin
            model_q.push_back(s0);
        end
        if (!exp_stall && req_1) begin
            model_q.push_back(s1);
        end
        done   = exp_valid && wb_ready_i;
        cyc_wr = 1'b0;
        ins_wr = 1'b0;
        if (done) begin
            e = model_q.pop_front();
            check_tag("wb_commit_id_o", e.cid, wb_commit_id_o);
            check_rd("wb_rd_o", e.rd, wb_rd_o);
            check_flag("wb_rd_we_o", e.rd_we, wb_rd_we_o);
            check_data("wb_rdata_o", read_model(e.addr), wb_rdata_o);
            seen_rd[e.addr] = wb_rdata_o;
            new_v = apply_op(e.op, read_model(e.addr), e.op1);
            if (e.csr_we && csr_index(e.addr) >= 0) begin
                rd_tmp = new_v & WMASK[csr_index(e.addr)];
                csr_m[csr_index(e.addr)] = rd_tmp;
            end
            cyc_wr = e.csr_we && (e.addr == CSR_MCYCLE || e.addr == CSR_MCYCLEH);
            ins_wr = e.csr_we && (e.addr == CSR_MINSTRET || e.addr == CSR_MINSTRETH);
        end
        // a counter write wins over its increment
        if (!cyc_wr) mcyc_m = mcyc_m + 1'b1;
        else if (e.addr == CSR_MCYCLE) mcyc_m[XLEN-1:0] = new_v;
        else mcyc_m[2*XLEN-1:XLEN] = new_v;
        if (ins_wr && e.addr == CSR_MINSTRET) minst_m[XLEN-1:0] = new_v;
        else if (ins_wr) minst_m[2*XLEN-1:XLEN] = new_v;
        else if (done) minst_m = minst_m + 1'b1;
        if (phase == 1) begin
            model_q.delete();
        end
        if (phase == 2) begin
            csr_m[0][MSTATUS_MPIE_BIT] = csr_m[0][MSTATUS_MIE_BIT];
            csr_m[0][MSTATUS_MIE_BIT]  = 1'b0;
            csr_m[4] = epc_m & 32'hFFFF_FFFC;
            csr_m[5] = MCAUSE_MEI;
        end
        phase = nxt;
    endtask

    task automatic run_cycle();
        @(posedge clk);
        drive();
        @(negedge clk);
        monitor();
    endtask

    task automatic drain();
        ready_mode = 2;
        do begin
            run_cycle();
        end while (model_q.size() != 0 || dir_q.size() != 0 || stalled);
    endtask

    initial begin
        #(PLAN_CYCLES * 20 * 20);
        $display("tests failed");
        $fatal(1, "watchdog timeout, the run did not finish in time");
    end

    initial begin
        seed       = 32'hde4c;
        clk        = 1'b0;
        rst_n      = 1'b0;
        irq_i      = 1'b0;
        pc_i       = IRQ_PC;  // held for the whole run
        req_0      = 1'b0;
        req_1      = 1'b0;
        s0         = '0;
        s1         = '0;
        wb_ready_i = 1'b0;
        foreach (csr_m[i]) csr_m[i] = '0;
        csr_m[2]   = MTVEC_RESET & 32'hFFFF_FFFC;
        mcyc_m     = '0;
        minst_m    = '0;
        next_cid   = '0;
        phase      = 0;
        ready_mode = 0;
        traps      = 0;
        rand_en    = 1'b0;
        stalled    = 1'b0;
        irq_req    = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        monitor();

        rand_en = 1'b1;
        repeat (RAND_CYCLES) run_cycle();
        ready_mode = 1;  // hold writeback so the queue fills
        repeat (12) run_cycle();
        if (!stall_o) abort_run("stall_o did not rise while writeback was held");
        ready_mode = 0;
        repeat (200) run_cycle();
        rand_en = 1'b0;
        drain();

        // interrupt entry with pending work in the queue
        queue_op(CSR_OP_RS, CSR_MSTATUS, 32'h1 << MSTATUS_MIE_BIT, 1'b1);
        queue_op(CSR_OP_RS, CSR_MIE, 32'h1 << MIE_MEIE_BIT, 1'b1);
        drain();
        ready_mode = 1;
        queue_op(CSR_OP_RW, CSR_MSCRATCH, 32'h1234_5678, 1'b1);
        queue_op(CSR_OP_RS, CSR_MSCRATCH, 32'h0000_00F0, 1'b1);
        queue_op(CSR_OP_RC, CSR_MTVEC, 32'h0000_0100, 1'b1);
        repeat (6) run_cycle();
        irq_req = 1'b1;
        while (traps == 0) run_cycle();
        irq_req = 1'b0;
        queue_op(CSR_OP_RS, CSR_MEPC, '0, 1'b0);
        queue_op(CSR_OP_RS, CSR_MCAUSE, '0, 1'b0);
        queue_op(CSR_OP_RS, CSR_MSTATUS, '0, 1'b0);
        drain();
        check_data("mepc", IRQ_PC, seen_rd[CSR_MEPC]);
        check_data("mcause", MCAUSE_MEI, seen_rd[CSR_MCAUSE]);
        rd_tmp = seen_rd[CSR_MSTATUS];
        check_flag("mstatus.MIE", 1'b0, rd_tmp[MSTATUS_MIE_BIT]);
        check_flag("mstatus.MPIE", 1'b1, rd_tmp[MSTATUS_MPIE_BIT]);

        // MIE is clear now so irq is ignored
        traps_before = traps;
        irq_req = 1'b1;
        repeat (20) run_cycle();
        irq_req = 1'b0;
        if (traps != traps_before) abort_run("trap taken while mstatus.MIE was clear");

        ready_mode = 0;
        rand_en = 1'b1;
        repeat (100) run_cycle();
        rand_en = 1'b0;
        drain();
        $display("all tests passed");
        $finish;
    end

endmodule

// File: csr_subsys.f
rtl/csr_pkg.sv
rtl/csr_if.sv
rtl/csr_exec_unit.sv
rtl/csr_regfile.sv
rtl/csr_counters.sv
rtl/csr_trap_fsm.sv
rtl/csr_subsys_top.sv
dv/csr_subsys_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = csr_subsys_tb
FILELIST = csr_subsys.f
OBJ_DIR  = obj_dir
SIM      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
